//--- compile.f
+incdir+.
accelPkg.sv
cpuBusCycle.sv
chipSelect.sv
ioQos.sv
memController.sv
ioBusBridge.sv
accelTop.sv
accelTb.sv

//--- accelPatterns.txt
# name op byteAddr wdata respData route(mem/io/none) rom posted expRData
# op is read, write, wslow (write with slow I/O ack) or gap (byteAddr = idle cycles)
ovlRom     read  000000 0000 1234 mem  1 0 1234
rom4x      read  400100 0000 4E71 mem  1 0 4E71
ovlRam     read  000000 0000 5678 mem  0 0 5678
ramWr      write 001000 A5A5 0000 mem  0 0 0000
latRd      read  0ABCDE 0000 9ABC mem  0 0 9ABC
vidWr      wslow 3F0000 1111 0000 mem  0 1 0000
bpFirst    wslow 3F1000 2222 0000 mem  0 1 0000
bpSecond   wslow 3F2000 3333 0000 mem  0 1 0000
ramAfterPw read  200000 0000 0F0F mem  0 0 0F0F
io5        read  500000 0000 5050 io   0 0 5050
io6        read  600002 0000 6060 io   0 0 6060
ioWr       write 600010 7777 0000 io   0 0 0000
io7        read  700000 0000 7070 io   0 0 7070
io8        read  800000 0000 8080 io   0 0 8080
ioA        read  A00000 0000 A0A0 io   0 0 A0A0
ioC        read  C00000 0000 C0C0 io   0 0 C0C0
io9        read  900000 0000 9090 io   0 0 9090
ioB        read  B00000 0000 B0B0 io   0 0 B0B0
ioD        read  D00000 0000 D0D0 io   0 0 D0D0
ioE        read  E00000 0000 E0E0 io   0 0 E0E0
iackF      read  FFFFF0 0000 0019 io   0 0 0019
gapQos     gap   000060 0000 0000 none 0 0 0000
qosDev     read  E00010 0000 1E1E io   0 0 1E1E
qosRam     read  100000 0000 2B2B io   0 0 2B2B
qosVid     write 3F3000 4444 0000 io   0 0 0000
gapOff     gap   000060 0000 0000 none 0 0 0000
qosOff     read  100000 0000 3C3C mem  0 0 3C3C
sndWr      write 3FFD00 5555 0000 mem  0 1 0000
sndRam     read  100002 0000 4D4D io   0 0 4D4D

//--- accelTb.sv
`timescale 1ns/10ps
`include "accel_consts.svh"

module accelTb;

	import accelPkg::*;

	localparam int Timeout = 200;  // Cycles allowed per wait

	logic        CLK;
	logic        rst;
	logic [22:0] cpuAddr;
	logic        nAS;
	logic        nWE;
	logic [15:0] cpuWData;
	logic [15:0] cpuRData;
	logic        nDTACK;
	memReqT      memReq;
	logic        memStrobe;
	logic [15:0] memRData;
	ioReqT       ioReq;
	logic        ioStrobe;
	logic [15:0] ioRData;
	logic        ioAck;

	// Expected bus traffic, oldest first
	memReqT memExp[$];
	string  memNames[$];
	bit     memPosted[$];
	ioReqT  ioExp[$];     // Entry leaves the queue at its ioAck
	string  ioNames[$];
	bit     ioSlow[$];    // Responder uses the longest delay

	integer      seed = 13278;
	int          errors = 0;
	int          checks = 0;
	bit          hung = 1'b0;
	logic [15:0] respData = 16'h0000;  // Responder data of the current line
	int          memWait = 0;
	int          ioWait = 0;
	bit          ioOwned = 1'b0;  // Open strobe matched an expected entry

	accelTop UUT (
		.CLK(CLK), .rst(rst), .cpuAddr(cpuAddr), .nAS(nAS), .nWE(nWE),
		.cpuWData(cpuWData), .cpuRData(cpuRData), .nDTACK(nDTACK),
		.memReq(memReq), .memStrobe(memStrobe), .memRData(memRData),
		.ioReq(ioReq), .ioStrobe(ioStrobe), .ioRData(ioRData), .ioAck(ioAck)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;  // 100 ns period

	task automatic checkMem(input string name, input memReqT exp, input memReqT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: memReq expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkIo(input string name, input ioReqT exp, input ioReqT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: ioReq expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkData(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: cpuRData expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkLatency(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Fail %s: DTACK latency expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Local memory, data valid only in the sampling cycle
	always @(negedge CLK) begin
		memRData = 16'hBAD0;
		if (memStrobe) begin
			memWait = `MEM_LATENCY;
			if (memExp.size() == 0) begin
				errors++;
				$display("Unexpected memStrobe with no memory cycle pending");
			end else begin
				checkMem(memNames[0], memExp[0], memReq);
				if (memPosted[0] && ioExp.size() > 1) begin  // Older posted write not acked
					errors++;
					$display("%s: memStrobe issued while the posted buffer was full", memNames[0]);
				end
				memExp.delete(0);
				memNames.delete(0);
				memPosted.delete(0);
			end
		end else if (memWait != 0) begin
			memWait--;
			if (memWait == 0)
				memRData = respData;
		end
	end

	// Slow bus with a random or long acknowledge delay
	always @(negedge CLK) begin
		ioAck   = 1'b0;
		ioRData = 16'hBAD1;
		if (ioWait != 0) begin
			ioWait--;
			if (ioWait == 0) begin
				ioAck   = 1'b1;  // One cycle pulse
				ioRData = respData;
				if (ioOwned) begin
					ioExp.delete(0);
					ioNames.delete(0);
					ioSlow.delete(0);
				end
			end
		end else if (ioStrobe) begin
			ioOwned = ioExp.size() != 0;
			if (!ioOwned) begin
				errors++;
				$display("Unexpected ioStrobe with no I/O cycle pending");
				ioWait = 1;
			end else begin
				checkIo(ioNames[0], ioExp[0], ioReq);
				if (ioSlow[0])
					ioWait = 20;
				else
					ioWait = ($unsigned($random(seed)) % 20) + 1;  // 1..20 cycles
			end
		end
	end

	// One CPU bus cycle from strobe to DTACK and release
	task automatic runCycle(input string name, input logic wr, input logic [23:0] byteAddr,
			input logic [15:0] wdata, input string route, input logic expRom,
			input logic posted, input logic slow, input logic [15:0] expRData);
		memReqT mExp;
		ioReqT  pExp;
		ioReqT  dExp;
		int     waited;
		mExp.addr  = byteAddr[23:1];
		mExp.we    = wr;
		mExp.rom   = expRom;
		mExp.wdata = wdata;
		pExp.addr  = byteAddr[23:1];  // Posted copy is always a write
		pExp.we    = 1'b1;
		pExp.wdata = wdata;
		pExp.iack  = 1'b0;
		dExp.addr  = byteAddr[23:1];
		dExp.we    = wr;
		dExp.wdata = wdata;
		dExp.iack  = byteAddr[23:20] == 4'hF;  // IACK region
		if (route == "mem") begin
			memExp.push_back(mExp);
			memNames.push_back(name);
			memPosted.push_back(posted);
		end
		if (posted) begin
			ioExp.push_back(pExp);
			ioNames.push_back(name);
			ioSlow.push_back(slow);
		end
		if (route == "io") begin
			ioExp.push_back(dExp);
			ioNames.push_back(name);
			ioSlow.push_back(1'b0);
		end
		cpuAddr  = byteAddr[23:1];
		cpuWData = wdata;
		nWE      = ~wr;
		nAS      = 1'b0;
		@(negedge CLK);
		waited = 1;
		while (nDTACK && waited < Timeout) begin
			@(negedge CLK);
			waited++;
		end
		if (nDTACK) begin
			errors++;
			hung = 1'b1;
			$display("%s: no DTACK within %0d cycles", name, Timeout);
		end else begin
			if (route == "mem" && !wr)
				checkLatency(name, `MEM_LATENCY + 2, waited - 1);  // From first nAS sample
			if (!wr)
				checkData(name, expRData, cpuRData);
			if (posted && slow && (ioExp.size() == 0 || ioExp[$] != pExp)) begin
				errors++;
				$display("%s: DTACK held until the posted write was acknowledged", name);
			end
			if (route == "mem" && memExp.size() != 0) begin
				errors++;
				$display("%s: memory cycle ended without a memStrobe", name);
			end
			if (route == "io" && ioExp.size() != 0) begin
				errors++;
				$display("%s: I/O cycle ended with bus requests still open", name);
			end
			nAS = 1'b1;
			nWE = 1'b1;
			@(negedge CLK);  // Lets bact drop before the next strobe
		end
	endtask

	initial begin : stimulus
		int               fd;
		int               nRead;
		int               rom;
		int               posted;
		int               waited;
		string            name;
		string            op;
		string            route;
		logic [23:0]      addr;
		logic [15:0]      wdata;
		logic [15:0]      resp;
		logic [15:0]      expRData;
		logic [8*120-1:0] skipLine;
		rst      = 1'b1;
		nAS      = 1'b1;
		nWE      = 1'b1;
		cpuAddr  = '0;
		cpuWData = '0;
		memRData = '0;
		ioRData  = '0;
		ioAck    = 1'b0;
		repeat (10) @(negedge CLK);
		rst = 1'b0;
		@(negedge CLK);
		fd = $fopen("accelPatterns.txt", "r");
		if (fd == 0) begin
			errors++;
			hung = 1'b1;
			$display("Cannot open the pattern file");
		end
		while (!hung && $fscanf(fd, "%s", name) == 1) begin
			if (name.getc(0) == "#") begin
				nRead = $fgets(skipLine, fd);  // Column notes
			end else begin
				nRead = $fscanf(fd, "%s %h %h %h %s %d %d %h", op, addr, wdata, resp, route,
					rom, posted, expRData);
				if (nRead != 8) begin
					errors++;
					hung = 1'b1;
					$display("Malformed pattern line at test %s", name);
				end else if (op == "gap") begin
					repeat (addr) @(negedge CLK);  // Idle bus
				end else begin
					respData = resp;
					runCycle(name, op != "read", addr, wdata, route, rom != 0, posted != 0,
						op == "wslow", expRData);
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		// Posted writes may still drain
		waited = 0;
		while (!hung && (ioExp.size() != 0 || memExp.size() != 0) && waited < Timeout) begin
			@(negedge CLK);
			waited++;
		end
		if (!hung && (ioExp.size() != 0 || memExp.size() != 0)) begin
			errors++;
			$display("Bus requests still pending at the end of the run");
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- accelTop.sv
`timescale 1ns/10ps

module accelTop (
	input  logic            CLK,
	input  logic            rst,
	// CPU bus
	input  logic [22:0]     cpuAddr,
	input  logic            nAS,
	input  logic            nWE,
	input  logic [15:0]     cpuWData,
	output logic [15:0]     cpuRData,
	output logic            nDTACK,
	// Local memory
	output accelPkg::memReqT memReq,
	output logic            memStrobe,
	input  logic [15:0]     memRData,
	// Slow I/O bus
	output accelPkg::ioReqT  ioReq,
	output logic            ioStrobe,
	input  logic [15:0]     ioRData,
	input  logic            ioAck
);

	import accelPkg::*;

	cpuCycleT    cyc;
	chipSelT     sel;
	logic        bact;
	logic        cycStart;
	logic        qosEn;
	logic        memDone;
	logic        ioDone;
	logic        pwReady;     // Posted buffer has room
	logic [15:0] ioRDataCap;  // Bridge read data at ioDone

	cpuBusCycle busCycle (
		.CLK(CLK), .rst(rst), .cpuAddr(cpuAddr), .nAS(nAS), .nWE(nWE),
		.cpuWData(cpuWData), .memDone(memDone), .ioDone(ioDone),
		.memRData(memRData), .ioRData(ioRDataCap), .cyc(cyc), .bact(bact),
		.cycStart(cycStart), .cpuRData(cpuRData), .nDTACK(nDTACK)
	);

	chipSelect decode (
		.CLK(CLK), .rst(rst), .cyc(cyc), .bact(bact), .qosEn(qosEn), .sel(sel)
	);

	ioQos qos (.CLK(CLK), .rst(rst), .cycStart(cycStart), .sel(sel), .qosEn(qosEn));

	memController memCtl (
		.CLK(CLK), .rst(rst), .cycStart(cycStart), .cyc(cyc), .sel(sel),
		.pwReady(pwReady), .memReq(memReq), .memStrobe(memStrobe), .memDone(memDone)
	);

	ioBusBridge bridge (
		.CLK(CLK), .rst(rst), .cycStart(cycStart), .cyc(cyc), .sel(sel),
		.ioRData(ioRData), .ioAck(ioAck), .ioReq(ioReq), .ioStrobe(ioStrobe),
		.ioDone(ioDone), .pwReady(pwReady), .ioRDataOut(ioRDataCap)
	);

endmodule

//--- ioBusBridge.sv
`timescale 1ns/10ps

module ioBusBridge (
	input  logic              CLK,
	input  logic              rst,
	input  logic              cycStart,
	input  accelPkg::cpuCycleT cyc,
	input  accelPkg::chipSelT  sel,
	input  logic [15:0]       ioRData,
	input  logic              ioAck,
	output accelPkg::ioReqT    ioReq,
	output logic              ioStrobe,
	output logic              ioDone,
	output logic              pwReady,
	output logic [15:0]       ioRDataOut
);

	import accelPkg::*;

	ioReqT pwBuf;    // Posted video write
	logic  pwValid;  // Buffer holds a write not yet acked
	logic  pwPend;   // Posted write waiting for room
	logic  pwTake;
	logic  pwLoad;
	logic  dmPend;   // Demand cycle waiting for the bus
	logic  busy;     // Strobe out, ack not yet seen
	logic  busPw;    // Outstanding cycle is the posted one
	logic  ackEnd;
	ioReqT dmReq;

	assign pwReady = ~pwValid;

	// New posted write or one held over from a full buffer
	assign pwTake = (cycStart && sel.ioPwCs) || pwPend;
	assign pwLoad = pwTake && !pwValid;
	assign ackEnd = busy && ioAck;

	// Demand request straight from the latched cycle
	always_comb begin
		dmReq.addr  = cyc.addr;
		dmReq.we    = cyc.we;
		dmReq.wdata = cyc.wdata;
		dmReq.iack  = sel.iackCs;
	end

	always_ff @(posedge CLK) begin
		if (pwLoad) begin
			pwBuf.addr  <= cyc.addr;
			pwBuf.we    <= 1'b1;
			pwBuf.wdata <= cyc.wdata;
			pwBuf.iack  <= 1'b0;
		end
	end

	// Read data taken at the ack edge
	always_ff @(posedge CLK) begin
		if (ackEnd && !busPw)
			ioRDataOut <= ioRData;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			pwValid  <= 1'b0;
			pwPend   <= 1'b0;
			dmPend   <= 1'b0;
			busy     <= 1'b0;
			busPw    <= 1'b0;
			ioStrobe <= 1'b0;
			ioDone   <= 1'b0;
		end else begin
			ioStrobe <= 1'b0;
			ioDone   <= 1'b0;

			// Posted buffer fill
			if (pwLoad) begin
				pwValid <= 1'b1;
				pwPend  <= 1'b0;
			end else if (cycStart && sel.ioPwCs) begin
				pwPend <= 1'b1;  // Loads once the buffer drains
			end

			if (cycStart && sel.ioCs)
				dmPend <= 1'b1;

			// Cycle end on ack
			if (ackEnd) begin
				busy <= 1'b0;
				if (busPw)
					pwValid <= 1'b0;  // Frees the buffer
				else
					ioDone <= 1'b1;   // Only demand cycles finish the CPU
			end

			// Issue, posted write first to keep bus order
			if (!busy) begin
				if (pwValid) begin
					ioReq    <= pwBuf;
					ioStrobe <= 1'b1;
					busy     <= 1'b1;
					busPw    <= 1'b1;
				end else if (dmPend) begin
					ioReq    <= dmReq;
					ioStrobe <= 1'b1;
					busy     <= 1'b1;
					busPw    <= 1'b0;
					dmPend   <= 1'b0;
				end
			end
		end
	end

endmodule

//--- memController.sv
`timescale 1ns/10ps
`include "accel_consts.svh"

module memController (
	input  logic              CLK,
	input  logic              rst,
	input  logic              cycStart,
	input  accelPkg::cpuCycleT cyc,
	input  accelPkg::chipSelT  sel,
	input  logic              pwReady,
	output accelPkg::memReqT   memReq,
	output logic              memStrobe,
	output logic              memDone
);

	localparam int CntW = `MEM_CNT_W;

	logic            start;   // Local memory cycle begins
	logic            waitPw;  // Held off by a full posted buffer
	logic            active;  // Strobe issued, counting latency
	logic [CntW-1:0] latCnt;
	logic            issue;

	// I/O cycles never touch local memory
	assign start = cycStart && !sel.ioCs && (sel.romCs || sel.ramCs);

	// Strobe now unless a posted write finds the buffer full
	assign issue = (start && !(sel.ioPwCs && !pwReady)) || (waitPw && pwReady);

	// Request is frozen at the start of the cycle
	always_ff @(posedge CLK) begin
		if (start) begin
			memReq.addr  <= cyc.addr;
			memReq.we    <= cyc.we;
			memReq.rom   <= sel.romCs;
			memReq.wdata <= cyc.wdata;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			waitPw    <= 1'b0;
			active    <= 1'b0;
			latCnt    <= '0;
			memStrobe <= 1'b0;
			memDone   <= 1'b0;
		end else begin
			memStrobe <= 1'b0;  // One cycle pulses
			memDone   <= 1'b0;
			if (issue) begin
				waitPw    <= 1'b0;
				active    <= 1'b1;
				memStrobe <= 1'b1;
				latCnt    <= CntW'(`MEM_LATENCY - 1);
			end else if (start) begin
				waitPw <= 1'b1;  // Back-pressure from the bridge
			end else if (active) begin
				if (latCnt == '0) begin
					active  <= 1'b0;
					memDone <= 1'b1;  // Data valid this cycle
				end else begin
					latCnt <= latCnt - 1'b1;
				end
			end
		end
	end

endmodule

//--- ioQos.sv
`timescale 1ns/10ps
`include "accel_consts.svh"

module ioQos (
	input  logic             CLK,
	input  logic             rst,
	input  logic             cycStart,
	input  accelPkg::chipSelT sel,
	output logic             qosEn
);

	localparam int CntW = `QOS_CNT_W;

	logic [CntW-1:0] qosCnt;  // Cycles left in the window
	logic            qosHit;

	// Timing-critical device or sound buffer access
	assign qosHit = cycStart && (sel.ioQosCs || sel.sndQosCs);

	always_ff @(posedge CLK) begin
		if (rst)
			qosCnt <= '0;
		else if (qosHit)
			qosCnt <= CntW'(`QOS_WINDOW);  // Every hit restarts the window
		else if (qosCnt != '0)
			qosCnt <= qosCnt - 1'b1;
	end

	// Lockstep while counting
	assign qosEn = qosCnt != '0;

endmodule

//--- chipSelect.sv
`timescale 1ns/10ps

module chipSelect (
	input  logic              CLK,
	input  logic              rst,
	input  accelPkg::cpuCycleT cyc,
	input  logic              bact,
	input  logic              qosEn,
	output accelPkg::chipSelT sel
);

	logic       overlay;  // ROM mirrored at zero after reset
	logic [3:0] region;   // A23..A20
	logic [7:0] page;     // A23..A16
	logic [3:0] sub;      // A15..A12
	logic [3:0] blk;      // A11..A8
	logic       rom4x;
	logic       ram0x;
	logic       vidWr;    // Any write into the 3F page
	logic       sndPage;
	logic       viaCs;
	logic       iwmCs;
	logic       sccCs;

	assign region = cyc.addr[22:19];
	assign page   = cyc.addr[22:15];
	assign sub    = cyc.addr[14:11];
	assign blk    = cyc.addr[10:7];

	// Overlay drops on the first 4xxxxx access
	always_ff @(posedge CLK) begin
		if (rst)
			overlay <= 1'b1;
		else if (bact && rom4x)
			overlay <= 1'b0;
	end

	assign rom4x = region == 4'h4;
	assign ram0x = cyc.addr[22:21] == 2'b00;  // 000000..3FFFFF
	assign vidWr = (page == 8'h3F) && cyc.we;

	// Device classes
	assign viaCs = region == 4'hE;
	assign iwmCs = region == 4'hD;
	assign sccCs = (region == 4'hB) || (region == 4'h9);  // Write and read halves

	// Sound buffer pages FD..FF and A1..A3
	always_comb begin
		sndPage = 1'b0;
		if (sub == 4'hF)
			sndPage = (blk == 4'hD) || (blk == 4'hE) || (blk == 4'hF);
		else if (sub == 4'hA)
			sndPage = (blk == 4'h1) || (blk == 4'h2) || (blk == 4'h3);
	end

	always_comb begin
		sel.iackCs   = region == 4'hF;
		sel.ioRealCs = region >= 4'h5;            // SCSI up to IACK with C folded in
		sel.rom4xCs  = rom4x;
		sel.romCs    = rom4x || (overlay && ram0x);
		sel.ram0xCs  = ram0x;
		sel.ramCs    = ram0x && !overlay;
		sel.ioQosCs  = viaCs || iwmCs || sccCs;
		sel.sndQosCs = vidWr && sndPage;
		// QoS on sends every cycle to the slow bus
		sel.ioCs     = sel.ioRealCs || qosEn;
		sel.ioPwCs   = vidWr && !qosEn;             // Posted only outside lockstep
	end

endmodule

//--- cpuBusCycle.sv
`timescale 1ns/10ps

module cpuBusCycle (
	input  logic              CLK,
	input  logic              rst,
	input  logic [22:0]       cpuAddr,   // A23..A1
	input  logic              nAS,
	input  logic              nWE,
	input  logic [15:0]       cpuWData,
	input  logic              memDone,
	input  logic              ioDone,
	input  logic [15:0]       memRData,
	input  logic [15:0]       ioRData,
	output accelPkg::cpuCycleT cyc,
	output logic              bact,
	output logic              cycStart,
	output logic [15:0]       cpuRData,
	output logic              nDTACK
);

	logic dtack;  // Active high DTACK level
	logic asLow;

	assign asLow = ~nAS;

	// Strobe edge detect, bact follows nAS by one cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			bact     <= 1'b0;
			cycStart <= 1'b0;
		end else begin
			bact     <= asLow;
			cycStart <= asLow & ~bact;  // First low sample only
		end
	end

	// Cycle latch, loaded once per strobe
	always_ff @(posedge CLK) begin
		if (asLow && !bact) begin
			cyc.addr  <= cpuAddr;
			cyc.we    <= ~nWE;
			cyc.wdata <= cpuWData;
		end
	end

	// Read data from whichever unit finished
	always_ff @(posedge CLK) begin
		if (memDone)
			cpuRData <= memRData;
		else if (ioDone)
			cpuRData <= ioRData;
	end

	// DTACK held until the CPU drops the strobe
	always_ff @(posedge CLK) begin
		if (rst)
			dtack <= 1'b0;
		else if (nAS)
			dtack <= 1'b0;
		else if (memDone || ioDone)
			dtack <= 1'b1;
	end

	assign nDTACK = ~dtack;

endmodule

//--- accelPkg.sv
package accelPkg;

	// One CPU bus cycle as latched at the address strobe
	typedef struct packed {
		logic [22:0] addr;  // Word address A23..A1
		logic        we;    // High for write
		logic [15:0] wdata;
	} cpuCycleT;

	// Decoded selects for the latched cycle
	typedef struct packed {
		logic iackCs;    // Interrupt acknowledge
		logic ioRealCs;  // Real I/O regions 5..F
		logic ioCs;      // Cycle runs on the I/O bus
		logic ioPwCs;    // Posted video write
		logic romCs;
		logic rom4xCs;   // 4xxxxx ROM region
		logic ramCs;
		logic ram0xCs;   // 000000..3FFFFF
		logic ioQosCs;   // VIA, IWM, SCC
		logic sndQosCs;  // Sound buffer writes
	} chipSelT;

	// Local memory request
	typedef struct packed {
		logic [22:0] addr;
		logic        we;
		logic        rom;   // 1 selects ROM, 0 RAM
		logic [15:0] wdata;
	} memReqT;

	// Slow I/O bus request
	typedef struct packed {
		logic [22:0] addr;
		logic        we;
		logic [15:0] wdata;
		logic        iack;  // Interrupt acknowledge cycle
	} ioReqT;

endpackage

//--- accel_consts.svh
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// Timing constants shared by the accelerator glue

// Lockstep window after a timing-critical device or sound access
// Counted in CLK cycles, 2 or more
`define QOS_WINDOW 64

// Local memory read latency
// Cycles from memStrobe to memRData sampling
`define MEM_LATENCY 2

// Counter widths derived from the above
`define QOS_CNT_W $clog2(`QOS_WINDOW + 1)
`define MEM_CNT_W (($clog2(`MEM_LATENCY + 1) > 0) ? $clog2(`MEM_LATENCY + 1) : 1)

`endif
